// ==== filelist.f ====
+incdir+src
src/mmu_pkg.sv
src/tlb_lookup_if.sv
src/dtlb.sv
src/access_check.sv
src/data_ram.sv
src/mmu_top.sv
verif/mmu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and fail if the log reports failure
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module mmu_tb -o mmu_tb_sim
./obj_dir/mmu_tb_sim > sim.log
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"

// ==== src/access_check.sv ====
/*
  Stage-2 fault decision for the command under lookup. Page faults come
  from privilege and write permission, access faults from the domain
  bits and the uncached address map. Purely combinational.
*/
`timescale 1ns/1ps
`include "mmu_settings.svh"

module access_check
  import mmu_pkg::*;
  (
  tlb_lookup_if.check_mp lookup,
  input  logic           is_store_i,
  input  priv_mode_e     priv_mode_i,
  input  logic           mstatus_sum_i,
  input  logic           uncached_mode_i,
  output logic           load_page_fault_o,
  output logic           store_page_fault_o,
  output logic           load_access_fault_o,
  output logic           store_access_fault_o
);

  logic priv_fault;
  logic write_fault;
  logic page_fault;
  logic did_fault;
  logic mode_fault;
  logic access_fault;

  // User needs u set, supervisor needs u clear unless SUM
  assign priv_fault = ((priv_mode_i == e_priv_user) & ~lookup.entry.u)
                    | ((priv_mode_i == e_priv_supervisor) & lookup.entry.u & ~mstatus_sum_i);

  assign write_fault = is_store_i & (~lookup.entry.w | ~lookup.entry.d);

  // No permission bits to check in bare mode
  assign page_fault = lookup.hit & ~lookup.bare & (priv_fault | write_fault);

  assign did_fault  = lookup.entry.ptag[`PTAG_W-1 -: `DID_W] != '0;
  assign mode_fault = uncached_mode_i & (lookup.entry.ptag >= `UNCACHED_PTAG_LIMIT);

  // Page fault takes precedence
  assign access_fault = lookup.hit & ~page_fault & (did_fault | mode_fault);

  assign load_page_fault_o    = page_fault & ~is_store_i;
  assign store_page_fault_o   = page_fault & is_store_i;
  assign load_access_fault_o  = access_fault & ~is_store_i;
  assign store_access_fault_o = access_fault & is_store_i;

endmodule

// ==== src/data_ram.sv ====
/*
  Single-cycle doubleword data RAM. Stores write the sized byte lanes,
  loads return the extended value one cycle later. Address bits below
  the access size are ignored.
*/
`timescale 1ns/1ps
`include "mmu_settings.svh"

module data_ram
  import mmu_pkg::*;
  (
  input  logic                    clk_i,
  input  logic                    en_i,
  input  logic                    we_i,
  input  mem_op_e                 op_i,
  input  logic [`RAM_ADDR_W+2:0]  paddr_i,
  input  logic [`DWORD_W-1:0]     wdata_i,
  output logic [`DWORD_W-1:0]     rdata_o
);

  localparam int BYTES = `DWORD_W / 8;

  logic [`DWORD_W-1:0]   mem [2**`RAM_ADDR_W];

  logic [`RAM_ADDR_W-1:0] index;
  logic [2:0]             size_mask;
  logic [BYTES-1:0]       size_en;
  logic [2:0]             offset;
  logic [BYTES-1:0]       lane_en;
  logic [`DWORD_W-1:0]    wdata_shift;
  logic [`DWORD_W-1:0]    rdata_shift;
  logic [`DWORD_W-1:0]    load_data;

  assign index = paddr_i[`RAM_ADDR_W+2:3];

  // Access size from opcode
  always_comb begin
    case (op_i)
      e_lb, e_lbu, e_sb: begin
        size_mask = 3'b111;
        size_en   = 8'h01;
      end
      e_lh, e_lhu, e_sh: begin
        size_mask = 3'b110;
        size_en   = 8'h03;
      end
      e_lw, e_lwu, e_sw: begin
        size_mask = 3'b100;
        size_en   = 8'h0f;
      end
      default: begin
        size_mask = 3'b000;
        size_en   = 8'hff;
      end
    endcase
  end

  assign offset      = paddr_i[2:0] & size_mask;
  assign lane_en     = size_en << offset;
  assign wdata_shift = wdata_i << {offset, 3'b000};
  assign rdata_shift = mem[index] >> {offset, 3'b000};

  always_comb begin
    case (op_i)
      e_lb:    load_data = {{56{rdata_shift[7]}}, rdata_shift[7:0]};
      e_lh:    load_data = {{48{rdata_shift[15]}}, rdata_shift[15:0]};
      e_lw:    load_data = {{32{rdata_shift[31]}}, rdata_shift[31:0]};
      e_lbu:   load_data = {56'b0, rdata_shift[7:0]};
      e_lhu:   load_data = {48'b0, rdata_shift[15:0]};
      e_lwu:   load_data = {32'b0, rdata_shift[31:0]};
      default: load_data = rdata_shift;
    endcase
  end

  // Read sees the old doubleword on a same-cycle write
  always_ff @(posedge clk_i) begin
    if (en_i && we_i) begin
      for (int b = 0; b < BYTES; b++) begin
        if (lane_en[b]) begin
          mem[index][b*8 +: 8] <= wdata_shift[b*8 +: 8];
        end
      end
    end
    if (en_i && !we_i) begin
      rdata_o <= load_data;
    end
  end

endmodule

// ==== src/dtlb.sv ====
/*
  Fully associative data TLB. One lookup per cycle with its result
  registered into the lookup interface; fills land on a matching entry
  or a round-robin victim. With translation off the tag passes through.
*/
`timescale 1ns/1ps
`include "mmu_settings.svh"

module dtlb
  import mmu_pkg::*;
  (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                translation_en_i,
  input  logic                lookup_v_i,
  input  logic [`VTAG_W-1:0]  lookup_vtag_i,
  input  logic                fill_v_i,
  input  logic [`VTAG_W-1:0]  fill_vtag_i,
  input  tlb_entry_t          fill_entry_i,
  input  logic                flush_i,
  tlb_lookup_if.tlb_mp        lookup
);

  localparam int IDX_W = $clog2(`TLB_ENTRIES);

  logic [`TLB_ENTRIES-1:0] valid_r;
  logic [`VTAG_W-1:0]      vtag_r [`TLB_ENTRIES];
  tlb_entry_t              entry_r [`TLB_ENTRIES];
  logic [IDX_W-1:0]        victim_r;

  logic [`TLB_ENTRIES-1:0] lookup_match;
  logic [`TLB_ENTRIES-1:0] fill_match;
  logic [IDX_W-1:0]        hit_idx;
  logic [IDX_W-1:0]        fill_idx;
  tlb_entry_t              bare_entry;

  // Tag compare and index select, lowest entry wins
  always_comb begin
    hit_idx  = '0;
    fill_idx = victim_r;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      lookup_match[i] = valid_r[i] & (vtag_r[i] == lookup_vtag_i);
      fill_match[i]   = valid_r[i] & (vtag_r[i] == fill_vtag_i);
    end
    for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
      if (lookup_match[i]) begin
        hit_idx = IDX_W'(i);
      end
      if (fill_match[i]) begin
        fill_idx = IDX_W'(i);
      end
    end
  end

  // Translation off: physical tag is the virtual tag
  assign bare_entry = '{ptag: `PTAG_W'(lookup_vtag_i), u: 1'b0, w: 1'b1, d: 1'b1};

  // Valid bits and victim pointer, flush beats fill
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_r  <= '0;
      victim_r <= '0;
    end else if (fill_v_i) begin
      valid_r[fill_idx] <= 1'b1;
      if (~|fill_match) begin
        victim_r <= (victim_r == IDX_W'(`TLB_ENTRIES - 1)) ? '0 : victim_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i && !flush_i) begin
      vtag_r[fill_idx]  <= fill_vtag_i;
      entry_r[fill_idx] <= fill_entry_i;
    end
  end

  // Lookup result for stage 2
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lookup.hit  <= 1'b0;
      lookup.miss <= 1'b0;
      lookup.bare <= 1'b0;
    end else begin
      lookup.hit  <= lookup_v_i & (~translation_en_i | (|lookup_match));
      lookup.miss <= lookup_v_i & translation_en_i & ~(|lookup_match);
      lookup.bare <= lookup_v_i & ~translation_en_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_v_i) begin
      lookup.entry <= translation_en_i ? entry_r[hit_idx] : bare_entry;
    end
  end

endmodule

// ==== src/mmu_pkg.sv ====
/*
  Shared types for the load/store memory unit: memory opcodes,
  privilege modes and the leaf TLB entry.
*/
`include "mmu_settings.svh"

package mmu_pkg;

  // Loads first, then stores
  typedef enum logic [3:0] {
    e_lb  = 4'h0,
    e_lh  = 4'h1,
    e_lw  = 4'h2,
    e_ld  = 4'h3,
    e_lbu = 4'h4,
    e_lhu = 4'h5,
    e_lwu = 4'h6,
    e_sb  = 4'h8,
    e_sh  = 4'h9,
    e_sw  = 4'ha,
    e_sd  = 4'hb
  } mem_op_e;

  // RISC-V privilege encoding
  typedef enum logic [1:0] {
    e_priv_user       = 2'b00,
    e_priv_supervisor = 2'b01,
    e_priv_machine    = 2'b11
  } priv_mode_e;

  // Leaf mapping, 31 bits
  typedef struct packed {
    logic [`PTAG_W-1:0] ptag;
    logic               u;
    logic               w;
    logic               d;
  } tlb_entry_t;

endpackage

// ==== src/mmu_settings.svh ====
/*
  Widths, sizes and address-map limits for the load/store memory unit.
  Included by the package and by every RTL file.
*/
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// Virtual address split
`define VADDR_W       39
`define PAGE_OFFSET_W 12
`define VTAG_W        27

// Physical tag, 40-bit physical address
`define PTAG_W        28
`define DID_W         3

// Page of address 2 GB, tags below are I/O space
`define UNCACHED_PTAG_LIMIT 28'h0080000

`define DWORD_W       64
`define RAM_ADDR_W    10
`define TLB_ENTRIES   8

`endif

// ==== src/mmu_top.sv ====
/*
  Load/store memory unit, three fixed stages: accept, translate and
  access, respond. A response leaves exactly two cycles after accept
  unless the command is poisoned in stage 2. TLB fills come from outside.
*/
`timescale 1ns/1ps
`include "mmu_settings.svh"

module mmu_top
  import mmu_pkg::*;
  (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 mmu_cmd_v_i,
  input  mem_op_e              mmu_cmd_op_i,
  input  logic [`VADDR_W-1:0]  mmu_cmd_vaddr_i,
  input  logic [`DWORD_W-1:0]  mmu_cmd_data_i,
  output logic                 mmu_cmd_ready_o,
  input  logic                 chk_poison_ex_i,
  input  priv_mode_e           priv_mode_i,
  input  logic                 translation_en_i,
  input  logic                 mstatus_sum_i,
  input  logic                 uncached_mode_i,
  input  logic                 tlb_fill_v_i,
  input  logic [`VTAG_W-1:0]   tlb_fill_vtag_i,
  input  tlb_entry_t           tlb_fill_entry_i,
  input  logic                 tlb_flush_i,
  output logic                 mem_resp_v_o,
  output logic [`DWORD_W-1:0]  mem_resp_data_o,
  output logic [`VADDR_W-1:0]  mem_resp_vaddr_o,
  output logic                 mem_resp_miss_o,
  output logic                 load_page_fault_o,
  output logic                 store_page_fault_o,
  output logic                 load_access_fault_o,
  output logic                 store_access_fault_o
);

  tlb_lookup_if lookup_if ();

  logic                 cmd_accept;
  logic                 cmd_v_r;
  mem_op_e              op_r;
  logic [`VADDR_W-1:0]  vaddr_r;
  logic [`DWORD_W-1:0]  data_r;

  logic                 live;
  logic                 is_store;
  logic                 lpf, spf, laf, saf;
  logic                 ram_en;
  logic [`RAM_ADDR_W+2:0] ram_paddr;
  logic [`DWORD_W-1:0]  ram_rdata;

  logic                 load_ok_rr;
  logic [`VADDR_W-1:0]  vaddr_rr;

  // Fill owns the TLB port this cycle
  assign mmu_cmd_ready_o = ~tlb_fill_v_i;
  assign cmd_accept      = mmu_cmd_v_i & mmu_cmd_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cmd_v_r <= 1'b0;
    end else begin
      cmd_v_r <= cmd_accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_accept) begin
      op_r    <= mmu_cmd_op_i;
      vaddr_r <= mmu_cmd_vaddr_i;
      data_r  <= mmu_cmd_data_i;
    end
  end

  dtlb dtlb_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .translation_en_i (translation_en_i),
    .lookup_v_i       (cmd_accept),
    .lookup_vtag_i    (mmu_cmd_vaddr_i[`VADDR_W-1:`PAGE_OFFSET_W]),
    .fill_v_i         (tlb_fill_v_i),
    .fill_vtag_i      (tlb_fill_vtag_i),
    .fill_entry_i     (tlb_fill_entry_i),
    .flush_i          (tlb_flush_i),
    .lookup           (lookup_if.tlb_mp)
  );

  // Stage 2
  assign live     = cmd_v_r & ~chk_poison_ex_i;
  assign is_store = op_r inside {e_sb, e_sh, e_sw, e_sd};

  access_check access_check_inst (
    .lookup               (lookup_if.check_mp),
    .is_store_i           (is_store),
    .priv_mode_i          (priv_mode_i),
    .mstatus_sum_i        (mstatus_sum_i),
    .uncached_mode_i      (uncached_mode_i),
    .load_page_fault_o    (lpf),
    .store_page_fault_o   (spf),
    .load_access_fault_o  (laf),
    .store_access_fault_o (saf)
  );

  assign ram_en    = live & lookup_if.hit & ~(lpf | spf | laf | saf);
  // Low tag bit joins the page offset to index the RAM
  assign ram_paddr = {lookup_if.entry.ptag[`RAM_ADDR_W+2-`PAGE_OFFSET_W:0],
                      vaddr_r[`PAGE_OFFSET_W-1:0]};

  data_ram data_ram_inst (
    .clk_i   (clk_i),
    .en_i    (ram_en),
    .we_i    (is_store),
    .op_i    (op_r),
    .paddr_i (ram_paddr),
    .wdata_i (data_r),
    .rdata_o (ram_rdata)
  );

  // Stage 3 response
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_resp_v_o         <= 1'b0;
      mem_resp_miss_o      <= 1'b0;
      load_page_fault_o    <= 1'b0;
      store_page_fault_o   <= 1'b0;
      load_access_fault_o  <= 1'b0;
      store_access_fault_o <= 1'b0;
      load_ok_rr           <= 1'b0;
    end else begin
      mem_resp_v_o         <= live;
      mem_resp_miss_o      <= live & lookup_if.miss;
      load_page_fault_o    <= live & lpf;
      store_page_fault_o   <= live & spf;
      load_access_fault_o  <= live & laf;
      store_access_fault_o <= live & saf;
      load_ok_rr           <= ram_en & ~is_store;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_v_r) begin
      vaddr_rr <= vaddr_r;
    end
  end

  assign mem_resp_vaddr_o = vaddr_rr;
  // Stores, misses and faults return zero
  assign mem_resp_data_o  = load_ok_rr ? ram_rdata : '0;

endmodule

// ==== src/tlb_lookup_if.sv ====
/*
  Registered TLB lookup result, valid the cycle after the lookup.
  Driven by the data TLB, read by the fault checker and the top level.
*/
`timescale 1ns/1ps
`include "mmu_settings.svh"

interface tlb_lookup_if
  import mmu_pkg::*;
  ();

  logic       hit;
  logic       miss;
  logic       bare;
  tlb_entry_t entry;

  modport tlb_mp (output hit, output miss, output bare, output entry);

  modport check_mp (input hit, input bare, input entry);

  modport top_mp (input hit, input miss, input entry);

endinterface

// ==== verif/mmu_tb.sv ====
/*
  Self-checking testbench for the load/store memory unit. Holds a RAM
  and TLB model, predicts each response at issue and checks it two
  cycles after accept. Run as top module mmu_tb.
*/
`timescale 1ns/1ps
`include "mmu_settings.svh"

module mmu_tb
  import mmu_pkg::*;
  ();

  localparam int NUM_CMDS   = 1508;
  localparam int MAX_CYCLES = 4 * NUM_CMDS + 200;

  typedef struct packed {
    logic [31:0]          due;
    logic [`DWORD_W-1:0]  data;
    logic [`VADDR_W-1:0]  vaddr;
    logic                 miss;
    logic                 lpf;
    logic                 spf;
    logic                 laf;
    logic                 saf;
  } exp_t;

  logic                clk_i;
  logic                reset_i;
  logic                mmu_cmd_v_i;
  mem_op_e             mmu_cmd_op_i;
  logic [`VADDR_W-1:0] mmu_cmd_vaddr_i;
  logic [`DWORD_W-1:0] mmu_cmd_data_i;
  logic                mmu_cmd_ready_o;
  logic                chk_poison_ex_i;
  priv_mode_e          priv_mode_i;
  logic                translation_en_i;
  logic                mstatus_sum_i;
  logic                uncached_mode_i;
  logic                tlb_fill_v_i;
  logic [`VTAG_W-1:0]  tlb_fill_vtag_i;
  tlb_entry_t          tlb_fill_entry_i;
  logic                tlb_flush_i;
  logic                mem_resp_v_o;
  logic [`DWORD_W-1:0] mem_resp_data_o;
  logic [`VADDR_W-1:0] mem_resp_vaddr_o;
  logic                mem_resp_miss_o;
  logic                load_page_fault_o;
  logic                store_page_fault_o;
  logic                load_access_fault_o;
  logic                store_access_fault_o;

  logic [`DWORD_W-1:0] mem_model [2**`RAM_ADDR_W];
  tlb_entry_t          tlb_model [logic [`VTAG_W-1:0]];
  exp_t                exp_q [$];
  exp_t                cur;
  logic [31:0]         lfsr = 32'hcb8f2be2;
  logic                poison_q = 1'b0;
  int                  cyc = 0;
  int                  errors = 0;
  int                  checked = 0;

  mem_op_e ops [11] = '{e_lb, e_lh, e_lw, e_ld, e_lbu, e_lhu, e_lwu, e_sb, e_sh, e_sw, e_sd};
  mem_op_e st_ops [4] = '{e_sb, e_sh, e_sw, e_sd};
  mem_op_e ls_ops [4] = '{e_lb, e_lh, e_lw, e_ld};
  mem_op_e lu_ops [4] = '{e_lbu, e_lhu, e_lwu, e_ld};
  logic [`VTAG_W-1:0] tags [8] = '{27'h12345, 27'h00abc, 27'h00777, 27'h00778,
                                   27'h00900, 27'h00901, 27'h00902, 27'h7ffff};

  mmu_top mmu_top_inst (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // One LFSR step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r[i] = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // Expected response from the translation and fault rules; updates the RAM model
  function automatic exp_t predict(input mem_op_e op, input logic [`VADDR_W-1:0] vaddr,
                                   input logic [`DWORD_W-1:0] data);
    exp_t               e;
    tlb_entry_t         ent;
    logic               store;
    logic               pf;
    logic               af;
    int                 nbytes;
    int                 off;
    logic [9:0]         idx;
    logic [63:0]        val;
    logic [`VTAG_W-1:0] vtag;
    e = '0;
    ent = '0;
    val = '0;
    pf = 1'b0;
    vtag = vaddr[`VADDR_W-1:`PAGE_OFFSET_W];
    store = op inside {e_sb, e_sh, e_sw, e_sd};
    e.vaddr = vaddr;
    if (translation_en_i && !tlb_model.exists(vtag)) begin
      e.miss = 1'b1;
      return e;
    end
    if (translation_en_i) begin
      ent = tlb_model[vtag];
      pf = (priv_mode_i == e_priv_user && !ent.u)
         || (priv_mode_i == e_priv_supervisor && ent.u && !mstatus_sum_i)
         || (store && !(ent.w && ent.d));
    end else begin
      ent.ptag = {1'b0, vtag};
    end
    af = !pf && (ent.ptag[27:25] != 3'b000
         || (uncached_mode_i && ent.ptag >= `UNCACHED_PTAG_LIMIT));
    e.lpf = pf & !store;
    e.spf = pf & store;
    e.laf = af & !store;
    e.saf = af & store;
    if (pf || af) begin
      return e;
    end
    case (op)
      e_lb, e_lbu, e_sb: nbytes = 1;
      e_lh, e_lhu, e_sh: nbytes = 2;
      e_lw, e_lwu, e_sw: nbytes = 4;
      default:           nbytes = 8;
    endcase
    off = int'(vaddr[2:0]) & ~(nbytes - 1);
    idx = {ent.ptag[0], vaddr[11:3]};
    for (int b = 0; b < nbytes; b++) begin
      if (store) begin
        mem_model[idx][(off + b) * 8 +: 8] = data[b * 8 +: 8];
      end else begin
        val[b * 8 +: 8] = mem_model[idx][(off + b) * 8 +: 8];
      end
    end
    // Sign fill only for lb, lh and lw
    for (int b = nbytes; b < 8; b++) begin
      val[b * 8 +: 8] = (op inside {e_lb, e_lh, e_lw} && val[nbytes * 8 - 1]) ? 8'hff : 8'h00;
    end
    if (!store) begin
      e.data = val;
    end
    return e;
  endfunction

  task automatic issue(input mem_op_e op, input logic [`VADDR_W-1:0] vaddr,
                       input logic [`DWORD_W-1:0] data, input logic poison);
    exp_t e;
    mmu_cmd_v_i = 1'b1;
    mmu_cmd_op_i = op;
    mmu_cmd_vaddr_i = vaddr;
    mmu_cmd_data_i = data;
    poison_q = poison;
    if (!poison) begin
      e = predict(op, vaddr, data);
      e.due = 32'(cyc + 2);
      exp_q.push_back(e);
    end
    @(posedge clk_i);
    #1;
    mmu_cmd_v_i = 1'b0;
    // Kill lands in stage 2 of this command
    chk_poison_ex_i = poison_q;
  endtask

  task automatic idle();
    @(posedge clk_i);
    #1;
    chk_poison_ex_i = 1'b0;
    poison_q = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      idle();
    end
  endtask

  task automatic rand_cmd(input logic [`VADDR_W-1:0] vaddr);
    issue(ops[rand_bits(4) % 11], vaddr, rand_bits(64), rand_bits(3) == 3'd0);
    if (rand_bits(2) == 2'd0) begin
      idle();
    end
  endtask

  task automatic tlb_fill(input logic [`VTAG_W-1:0] vtag, input tlb_entry_t entry);
    tlb_fill_v_i = 1'b1;
    tlb_fill_vtag_i = vtag;
    tlb_fill_entry_i = entry;
    tlb_model[vtag] = entry;
    idle();
    tlb_fill_v_i = 1'b0;
  endtask

  task automatic tlb_flush();
    tlb_flush_i = 1'b1;
    tlb_model.delete();
    idle();
    tlb_flush_i = 1'b0;
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d responses outstanding", cyc, exp_q.size());
      $display("Errors %0d, responses checked %0d", errors, checked);
      $display("TB FAILED");
      $finish;
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (!reset_i) begin
      assert (mmu_cmd_ready_o == !tlb_fill_v_i) else begin
        errors++;
        $display("MISMATCH at %0t: mmu_cmd_ready_o got %b expected %b",
                 $time, mmu_cmd_ready_o, !tlb_fill_v_i);
      end
      if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
        cur = exp_q.pop_front();
        checked++;
        assert (mem_resp_v_o) else begin
          errors++;
          $display("No response at %0t for the command to %h", $time, cur.vaddr);
        end
        compare("mem_resp_data_o", mem_resp_data_o, cur.data);
        compare("mem_resp_vaddr_o", 64'(mem_resp_vaddr_o), 64'(cur.vaddr));
        compare("mem_resp_miss_o", 64'(mem_resp_miss_o), 64'(cur.miss));
        compare("load_page_fault_o", 64'(load_page_fault_o), 64'(cur.lpf));
        compare("store_page_fault_o", 64'(store_page_fault_o), 64'(cur.spf));
        compare("load_access_fault_o", 64'(load_access_fault_o), 64'(cur.laf));
        compare("store_access_fault_o", 64'(store_access_fault_o), 64'(cur.saf));
      end else begin
        assert (!mem_resp_v_o) else begin
          errors++;
          $display("Response at %0t with no command due", $time);
        end
      end
    end
  end

  initial begin
    reset_i = 1'b1;
    mmu_cmd_v_i = 1'b0;
    mmu_cmd_op_i = e_lb;
    mmu_cmd_vaddr_i = '0;
    mmu_cmd_data_i = '0;
    chk_poison_ex_i = 1'b0;
    priv_mode_i = e_priv_machine;
    translation_en_i = 1'b0;
    mstatus_sum_i = 1'b0;
    uncached_mode_i = 1'b0;
    tlb_fill_v_i = 1'b0;
    tlb_fill_vtag_i = '0;
    tlb_fill_entry_i = '0;
    tlb_flush_i = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    assert (!mem_resp_v_o && mem_resp_data_o == '0 && !mem_resp_miss_o && mmu_cmd_ready_o
            && !load_page_fault_o && !store_page_fault_o
            && !load_access_fault_o && !store_access_fault_o) else begin
      errors++;
      $display("Outputs not quiet at the end of reset");
    end
    reset_i = 1'b0;

    // Every RAM doubleword written in bare mode before any load
    for (int i = 0; i < 1024; i++) begin
      issue(e_sd, 39'(i * 8), rand_bits(64), 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      issue(st_ops[i], 39'(12'h203 + i * 8), rand_bits(64) | 64'h8080808080808080, 1'b0);
      issue(ls_ops[i], 39'(12'h203 + i * 8), '0, 1'b0);
      issue(lu_ops[i], 39'(12'h203 + i * 8), '0, 1'b0);
    end
    issue(e_sd, 39'h100, rand_bits(64), 1'b1);
    issue(e_ld, 39'h100, '0, 1'b0);
    repeat (300) rand_cmd(39'(rand_bits(13)));
    drain();

    translation_en_i = 1'b1;
    priv_mode_i = e_priv_supervisor;
    tlb_fill(tags[0], '{ptag: 28'h40, u: 1'b0, w: 1'b1, d: 1'b1});
    tlb_fill(tags[1], '{ptag: 28'h41, u: 1'b1, w: 1'b1, d: 1'b1});
    tlb_fill(tags[2], '{ptag: 28'h42, u: 1'b0, w: 1'b0, d: 1'b1});
    tlb_fill(tags[3], '{ptag: 28'h43, u: 1'b0, w: 1'b1, d: 1'b0});
    tlb_fill(tags[4], '{ptag: 28'h2000000, u: 1'b0, w: 1'b1, d: 1'b1});
    tlb_fill(tags[5], '{ptag: 28'h0090000, u: 1'b0, w: 1'b1, d: 1'b1});
    tlb_fill(tags[6], '{ptag: 28'h007ffff, u: 1'b0, w: 1'b1, d: 1'b1});
    // Command held through a fill goes in one cycle later
    mmu_cmd_v_i = 1'b1;
    mmu_cmd_op_i = e_ld;
    mmu_cmd_vaddr_i = {tags[0], 12'h018};
    tlb_fill(27'h00abd, '{ptag: 28'h45, u: 1'b0, w: 1'b1, d: 1'b1});
    issue(e_ld, {tags[0], 12'h018}, '0, 1'b0);

    // Supervisor, supervisor with SUM, user, then uncached
    for (int c = 0; c < 4; c++) begin
      drain();
      priv_mode_i = (c == 2) ? e_priv_user : e_priv_supervisor;
      mstatus_sum_i = (c == 1);
      uncached_mode_i = (c == 3);
      repeat (40) rand_cmd({tags[rand_bits(3)], 12'(rand_bits(12))});
      if (c == 0) begin
        issue(e_sd, {tags[2], 12'h010}, rand_bits(64), 1'b0);
        issue(e_ld, {tags[0], 12'h010}, '0, 1'b0);
      end
    end
    drain();

    tlb_flush();
    for (int i = 0; i < 7; i++) begin
      issue(e_ld, {tags[i], 12'h008}, '0, 1'b0);
    end
    drain();
    repeat (4) idle();

    $display("Errors %0d, responses checked %0d", errors, checked);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
